// File: design/cpu4_pkg.sv
package cpu4_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // widths and types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int NIBBLE_W = 4;
  localparam int ADDR_W   = 8;
  localparam int PC_W     = 12;
  localparam int INSTR_W  = 12;
  localparam int FLAGS_W  = 4;

  typedef logic [NIBBLE_W-1:0] nibble_t;
  typedef logic [ADDR_W-1:0]   addr8_t;
  typedef logic [PC_W-1:0]     pc_t;
  typedef logic [INSTR_W-1:0]  instr_t;
  typedef logic [FLAGS_W-1:0]  flags_t;

  // flag bits.
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_D = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [7:0] OPC_ADD_RQ = 8'hA8; // top 8 bits.
  localparam logic [3:0] OPC_ADD_RI = 4'hC;  // top 4 bits.
  localparam logic [3:0] OPC_LD_RI  = 4'hE;
  localparam logic [7:0] OPC_LD_RQ  = 8'hEC;
  localparam logic [3:0] OPC_LDY    = 4'h8;
  localparam logic [3:0] OPC_LDX    = 4'hB;
  localparam logic [7:0] OPC_SETF   = 8'hF4;
  localparam logic [7:0] OPC_RSTF   = 8'hF5;

  // r/q operand selects.
  localparam logic [1:0] SEL_A  = 2'd0;
  localparam logic [1:0] SEL_B  = 2'd1;
  localparam logic [1:0] SEL_MX = 2'd2;
  localparam logic [1:0] SEL_MY = 2'd3;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADD,
    OP_LD,
    OP_LDX,
    OP_LDY,
    OP_SETF,
    OP_RSTF
  } op_e;

  // one instruction walks these in order, 7 clocks.
  typedef enum logic [2:0] {
    PH_FETCH,
    PH_DECODE,
    PH_ADDR,
    PH_READ,
    PH_EXEC,
    PH_WRITE,
    PH_NEXT
  } phase_e;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             done_strobe,
  input  cpu4_pkg::instr_t rom_data,
  output cpu4_pkg::pc_t    rom_addr,
  output cpu4_pkg::instr_t instr,
  output logic             instr_strobe,
  output cpu4_pkg::phase_e phase
);
  import cpu4_pkg::*;

  pc_t    pc;
  phase_e phase_nxt;

  assign rom_addr = pc;

  always_comb begin
    case (phase)
      PH_FETCH:  phase_nxt = PH_DECODE;
      PH_DECODE: phase_nxt = PH_ADDR;
      PH_ADDR:   phase_nxt = PH_READ;
      PH_READ:   phase_nxt = PH_EXEC;
      PH_EXEC:   phase_nxt = PH_WRITE;
      PH_WRITE:  phase_nxt = PH_NEXT;
      default:   phase_nxt = PH_FETCH; // wrap after PH_NEXT.
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // phase counter and pc.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase        <= PH_FETCH;
      pc           <= '0;
      instr_strobe <= 1'b0;
    end else begin
      phase        <= phase_nxt;
      instr_strobe <= (phase == PH_FETCH);
      if (done_strobe) begin
        pc <= pc + 1'b1; // lands at the end of PH_NEXT.
      end
    end
  end

  // instruction word.
  always_ff @(posedge clk) begin
    if (phase == PH_FETCH) begin
      instr <= rom_data;
    end
  end

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              instr_strobe,
  input  cpu4_pkg::instr_t  instr,
  output cpu4_pkg::op_e     op,
  output logic [1:0]        dst_sel,
  output logic [1:0]        src_sel,
  output cpu4_pkg::nibble_t imm,
  output cpu4_pkg::addr8_t  imm8,
  output logic              dec_strobe
);
  import cpu4_pkg::*;

  op_e        op_d;
  logic [1:0] dst_d;
  logic [1:0] src_d;
  nibble_t    imm_d;
  addr8_t     imm8_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pattern match, first hit wins.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    op_d   = OP_NOP;
    dst_d  = instr[3:2];
    src_d  = instr[1:0];
    imm_d  = instr[3:0];
    imm8_d = instr[7:0]; // register forms keep bit 7 set.

    if (instr[11:4] == OPC_ADD_RQ) begin
      op_d = OP_ADD;
    end else if (instr[11:8] == OPC_ADD_RI) begin
      op_d   = OP_ADD;
      dst_d  = instr[5:4];
      imm8_d = {4'h0, instr[3:0]}; // bit 7 clear marks the immediate.
    end else if (instr[11:4] == OPC_LD_RQ) begin
      op_d = OP_LD; // must beat LD r,i.
    end else if (instr[11:8] == OPC_LD_RI) begin
      op_d   = OP_LD;
      dst_d  = instr[5:4];
      imm8_d = {4'h0, instr[3:0]};
    end else if (instr[11:8] == OPC_LDY) begin
      op_d = OP_LDY;
    end else if (instr[11:8] == OPC_LDX) begin
      op_d = OP_LDX;
    end else if (instr[11:4] == OPC_SETF) begin
      op_d = OP_SETF;
    end else if (instr[11:4] == OPC_RSTF) begin
      op_d = OP_RSTF;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op         <= OP_NOP;
      dec_strobe <= 1'b0;
    end else begin
      dec_strobe <= instr_strobe;
      if (instr_strobe) begin
        op <= op_d;
      end
    end
  end

  // operand fields.
  always_ff @(posedge clk) begin
    if (instr_strobe) begin
      dst_sel <= dst_d;
      src_sel <= src_d;
      imm     <= imm_d;
      imm8    <= imm8_d;
    end
  end

endmodule

// File: design/operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              dec_strobe,
  input  cpu4_pkg::op_e     op,
  input  logic [1:0]        dst_sel,
  input  logic [1:0]        src_sel,
  input  cpu4_pkg::nibble_t imm,
  input  cpu4_pkg::addr8_t  imm8,
  input  logic              wr_en,
  input  logic [1:0]        wr_sel,
  input  cpu4_pkg::nibble_t wr_data,
  input  cpu4_pkg::addr8_t  ram_addr_wr,
  output cpu4_pkg::addr8_t  ram_addr,
  input  cpu4_pkg::nibble_t ram_rdata,
  output cpu4_pkg::addr8_t  ram_addr_x,
  output cpu4_pkg::addr8_t  ram_addr_y,
  output cpu4_pkg::nibble_t opa,
  output cpu4_pkg::nibble_t opb,
  output logic              opnd_strobe
);
  import cpu4_pkg::*;

  nibble_t    reg_a;
  nibble_t    reg_b;
  addr8_t     reg_x;
  addr8_t     reg_y;
  logic       rd_src;    // high in PH_READ.
  logic [1:0] sel_now;
  nibble_t    sel_data;
  logic       src_is_imm;

  assign ram_addr_x = reg_x;
  assign ram_addr_y = reg_y;
  assign src_is_imm = (op == OP_ADD || op == OP_LD) && !imm8[7];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ram address and operand mux.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sel_now = rd_src ? src_sel : dst_sel; // destination goes first.

  always_comb begin
    if (dec_strobe || rd_src) begin
      ram_addr = (sel_now == SEL_MY) ? reg_y : reg_x;
    end else begin
      ram_addr = ram_addr_wr; // write back address otherwise.
    end
  end

  always_comb begin
    case (sel_now)
      SEL_A:   sel_data = reg_a;
      SEL_B:   sel_data = reg_b;
      default: sel_data = ram_rdata;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a       <= '0;
      reg_b       <= '0;
      reg_x       <= '0;
      reg_y       <= '0;
      rd_src      <= 1'b0;
      opnd_strobe <= 1'b0;
    end else begin
      rd_src      <= dec_strobe;
      opnd_strobe <= rd_src;
      if (dec_strobe && op == OP_LDX) reg_x <= imm8;
      if (dec_strobe && op == OP_LDY) reg_y <= imm8;
      if (wr_en) begin
        case (wr_sel)
          SEL_A:   reg_a <= wr_data;
          SEL_B:   reg_b <= wr_data;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dec_strobe) opa <= sel_data;
    if (rd_src)     opb <= src_is_imm ? imm : sel_data;
  end

endmodule

// File: design/alu_stage.sv
`timescale 1ns/100ps

module alu_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              opnd_strobe,
  input  cpu4_pkg::op_e     op,
  input  logic              decimal,
  input  cpu4_pkg::nibble_t opa,
  input  cpu4_pkg::nibble_t opb,
  output cpu4_pkg::nibble_t result,
  output logic              carry_out,
  output logic              zero_out,
  output logic              alu_strobe
);
  import cpu4_pkg::*;

  logic [4:0] sum;
  logic [4:0] adj;
  logic       carry_d;
  nibble_t    res_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // add with optional bcd adjust.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sum = {1'b0, opa} + {1'b0, opb};

  always_comb begin
    if (decimal && sum >= 5'd10) begin
      adj     = sum - 5'd10;
      carry_d = 1'b1;
    end else begin
      adj     = sum;
      carry_d = sum[4];
    end
  end

  always_comb begin
    case (op)
      OP_ADD:  res_d = adj[3:0];
      default: res_d = opb; // loads pass the source.
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_strobe <= 1'b0;
    end else begin
      alu_strobe <= opnd_strobe;
    end
  end

  always_ff @(posedge clk) begin
    if (opnd_strobe) begin
      result    <= res_d;
      carry_out <= carry_d;
      zero_out  <= (res_d == '0);
    end
  end

endmodule

// File: design/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              alu_strobe,
  input  cpu4_pkg::op_e     op,
  input  logic [1:0]        dst_sel,
  input  cpu4_pkg::nibble_t imm,
  input  cpu4_pkg::nibble_t result,
  input  logic              carry_out,
  input  logic              zero_out,
  input  cpu4_pkg::addr8_t  ram_addr_x,
  input  cpu4_pkg::addr8_t  ram_addr_y,
  output cpu4_pkg::addr8_t  ram_addr_wr,
  output cpu4_pkg::nibble_t ram_wdata,
  output logic              ram_we,
  output logic              wr_en,
  output logic [1:0]        wr_sel,
  output cpu4_pkg::nibble_t wr_data,
  output cpu4_pkg::flags_t  flags,
  output logic              decimal,
  output logic              done_strobe
);
  import cpu4_pkg::*;

  logic writes_dst;
  logic dst_is_ram;

  assign writes_dst = (op == OP_ADD) || (op == OP_LD);
  assign dst_is_ram = (dst_sel == SEL_MX) || (dst_sel == SEL_MY);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result routing, all in PH_WRITE.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ram_addr_wr = (dst_sel == SEL_MY) ? ram_addr_y : ram_addr_x;
  assign ram_wdata   = result;
  assign ram_we      = alu_strobe & writes_dst & dst_is_ram;  // one clock.
  assign wr_en       = alu_strobe & writes_dst & ~dst_is_ram;
  assign wr_sel      = dst_sel;
  assign wr_data     = result;
  assign decimal     = flags[FLAG_D];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags       <= '0;
      done_strobe <= 1'b0;
    end else begin
      done_strobe <= alu_strobe; // pc steps on this.
      if (alu_strobe) begin
        case (op)
          OP_ADD: begin
            flags[FLAG_C] <= carry_out;
            flags[FLAG_Z] <= zero_out;
          end
          OP_SETF: flags <= flags | imm;
          OP_RSTF: flags <= flags & ~imm;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: design/cpu4_core.sv
`timescale 1ns/100ps

module cpu4_core (
  input  logic              clk,
  input  logic              arst_n,
  input  cpu4_pkg::instr_t  rom_data,
  input  cpu4_pkg::nibble_t ram_rdata,
  output cpu4_pkg::pc_t     rom_addr,
  output cpu4_pkg::addr8_t  ram_addr,
  output cpu4_pkg::nibble_t ram_wdata,
  output logic              ram_we,
  output cpu4_pkg::flags_t  flags
);
  import cpu4_pkg::*;

  // stage to stage.
  instr_t     instr;
  logic       instr_strobe;
  op_e        op;
  logic [1:0] dst_sel;
  logic [1:0] src_sel;
  nibble_t    imm;
  addr8_t     imm8;
  logic       dec_strobe;
  nibble_t    opa;
  nibble_t    opb;
  logic       opnd_strobe;
  nibble_t    result;
  logic       carry_out;
  logic       zero_out;
  logic       alu_strobe;
  logic       done_strobe;
  logic       decimal;

  // write back to register file.
  logic       wr_en;
  logic [1:0] wr_sel;
  nibble_t    wr_data;
  addr8_t     ram_addr_wr;
  addr8_t     ram_addr_x;
  addr8_t     ram_addr_y;

  fetch_stage fetch_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .done_strobe  (done_strobe),
    .rom_data     (rom_data),
    .rom_addr     (rom_addr),
    .instr        (instr),
    .instr_strobe (instr_strobe),
    .phase        ()
  );

  decode_stage decode_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_strobe (instr_strobe),
    .instr        (instr),
    .op           (op),
    .dst_sel      (dst_sel),
    .src_sel      (src_sel),
    .imm          (imm),
    .imm8         (imm8),
    .dec_strobe   (dec_strobe)
  );

  operand_stage operand_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .dec_strobe   (dec_strobe),
    .op           (op),
    .dst_sel      (dst_sel),
    .src_sel      (src_sel),
    .imm          (imm),
    .imm8         (imm8),
    .wr_en        (wr_en),
    .wr_sel       (wr_sel),
    .wr_data      (wr_data),
    .ram_addr_wr  (ram_addr_wr),
    .ram_addr     (ram_addr),
    .ram_rdata    (ram_rdata),
    .ram_addr_x   (ram_addr_x),
    .ram_addr_y   (ram_addr_y),
    .opa          (opa),
    .opb          (opb),
    .opnd_strobe  (opnd_strobe)
  );

  alu_stage alu_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .opnd_strobe  (opnd_strobe),
    .op           (op),
    .decimal      (decimal),
    .opa          (opa),
    .opb          (opb),
    .result       (result),
    .carry_out    (carry_out),
    .zero_out     (zero_out),
    .alu_strobe   (alu_strobe)
  );

  writeback_stage writeback_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .alu_strobe   (alu_strobe),
    .op           (op),
    .dst_sel      (dst_sel),
    .imm          (imm),
    .result       (result),
    .carry_out    (carry_out),
    .zero_out     (zero_out),
    .ram_addr_x   (ram_addr_x),
    .ram_addr_y   (ram_addr_y),
    .ram_addr_wr  (ram_addr_wr),
    .ram_wdata    (ram_wdata),
    .ram_we       (ram_we),
    .wr_en        (wr_en),
    .wr_sel       (wr_sel),
    .wr_data      (wr_data),
    .flags        (flags),
    .decimal      (decimal),
    .done_strobe  (done_strobe)
  );

endmodule

// File: verif/cpu4_checker.sv
`timescale 1ns/100ps

module cpu4_checker (
  input logic             clk,
  input logic             arst_n,
  input cpu4_pkg::pc_t    rom_addr,
  input logic             ram_we,
  input cpu4_pkg::flags_t flags
);
  import cpu4_pkg::*;

  pc_t        last_addr;
  logic [2:0] hold_cnt; // clocks since rom_addr last moved.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_addr <= '0;
      hold_cnt  <= '0;
    end else begin
      last_addr <= rom_addr;
      if (rom_addr != last_addr) begin
        hold_cnt <= '0;
      end else if (hold_cnt != 3'd7) begin
        hold_cnt <= hold_cnt + 3'd1; // saturates.
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port properties.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  ram_we_single: assert property (@(posedge clk) disable iff (!arst_n)
    ram_we |=> !ram_we)
    else $error("ram_we high for more than one clock");

  pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (rom_addr != last_addr) |-> (hold_cnt >= 3'd6))
    else $error("rom_addr moved before holding for 6 clocks");

  flags_in_reset: assert property (@(posedge clk)
    !arst_n |-> (flags == '0))
    else $error("flags not zero during reset");

endmodule

bind cpu4_core cpu4_checker cpu4_checker_inst (
  .clk      (clk),
  .arst_n   (arst_n),
  .rom_addr (rom_addr),
  .ram_we   (ram_we),
  .flags    (flags)
);

// File: verif/cpu4_tb.sv
`timescale 1ns/100ps

module cpu4_tb;
  import cpu4_pkg::*;

  localparam int          PROG_LEN   = 160;
  localparam int          RST_CYCLES = 10;
  localparam int          CLK_NS     = 10;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

  logic    clk;
  logic    arst_n;
  instr_t  rom_data;
  nibble_t ram_rdata;
  pc_t     rom_addr;
  addr8_t  ram_addr;
  nibble_t ram_wdata;
  logic    ram_we;
  flags_t  flags;

  instr_t      rom [0:4095];
  nibble_t     ram [0:255];
  logic [31:0] lfsr_state;

  // reference model state.
  nibble_t m_a;
  nibble_t m_b;
  addr8_t  m_x;
  addr8_t  m_y;
  flags_t  m_flags;
  nibble_t m_mem [0:255];

  cpu4_core cpu4_core_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .rom_data  (rom_data),
    .ram_rdata (ram_rdata),
    .rom_addr  (rom_addr),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_we    (ram_we),
    .flags     (flags)
  );

  assign rom_data  = rom[rom_addr];
  assign ram_rdata = ram[ram_addr]; // combinational read.

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  initial begin
    #((RST_CYCLES + 7 * PROG_LEN + 50) * CLK_NS);
    $display("watchdog timeout: the program did not complete in time");
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // program generator.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [11:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[10:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic build_program();
    logic [11:0] kind;
    logic [11:0] r;
    lfsr_state = 32'd70708;
    for (int a = 0; a < 4096; a++) begin
      rom[a] = 12'h000; // top nibble 0 decodes as no-op.
    end
    take_bits(8, r);
    rom[0] = {OPC_LDX, r[7:0]};
    take_bits(8, r);
    rom[1] = {OPC_LDY, r[7:0]};
    take_bits(1, r);
    rom[2] = {(r[0] ? OPC_SETF : OPC_RSTF), 4'(1 << FLAG_D)};
    for (int k = 3; k < PROG_LEN; k++) begin
      take_bits(3, kind);
      take_bits(9, r);
      case (kind[2:0])
        3'd0:    rom[k] = {OPC_LD_RI, 2'b00, r[5:0]};
        3'd1:    rom[k] = {OPC_ADD_RQ, r[3:0]};
        3'd2:    rom[k] = {OPC_ADD_RI, 2'b00, r[5:0]};
        3'd3:    rom[k] = r[8] ? {OPC_LD_RQ, SEL_MX, SEL_A} : {OPC_LD_RQ, SEL_MY, SEL_B};
        3'd4:    rom[k] = {OPC_LD_RQ, r[3:0]};
        3'd5:    rom[k] = {(r[8] ? OPC_SETF : OPC_RSTF), r[3:0]};
        3'd6:    rom[k] = {4'h0, r[7:0]};
        default: rom[k] = {(r[8] ? OPC_LDX : OPC_LDY), r[7:0]};
      endcase
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and compare.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic nibble_t read_operand(input logic [1:0] sel);
    case (sel)
      SEL_A:   return m_a;
      SEL_B:   return m_b;
      SEL_MX:  return m_mem[m_x];
      default: return m_mem[m_y];
    endcase
  endfunction

  task automatic execute_model(input instr_t ins, output logic we, output addr8_t addr,
                               output nibble_t data);
    logic       is_add;
    logic       is_ld;
    logic       imm_form;
    logic [1:0] dst;
    nibble_t    res;
    logic [4:0] sum;
    we       = 1'b0;
    addr     = '0;
    data     = '0;
    is_add   = (ins[11:4] == OPC_ADD_RQ) || (ins[11:8] == OPC_ADD_RI);
    is_ld    = (ins[11:4] == OPC_LD_RQ) || (ins[11:8] == OPC_LD_RI);
    imm_form = (ins[11:8] == OPC_ADD_RI) ||
               (ins[11:8] == OPC_LD_RI && ins[11:4] != OPC_LD_RQ);
    dst      = imm_form ? ins[5:4] : ins[3:2];
    res      = imm_form ? ins[3:0] : read_operand(ins[1:0]);
    if (is_add) begin
      sum = {1'b0, read_operand(dst)} + {1'b0, res};
      if (m_flags[FLAG_D] && sum >= 5'd10) begin
        sum            = sum - 5'd10; // bcd wrap.
        m_flags[FLAG_C] = 1'b1;
      end else begin
        m_flags[FLAG_C] = sum[4];
      end
      res             = sum[3:0];
      m_flags[FLAG_Z] = (res == 4'h0);
    end
    if (is_add || is_ld) begin
      if (dst == SEL_A) begin
        m_a = res;
      end else if (dst == SEL_B) begin
        m_b = res;
      end else begin
        we          = 1'b1;
        addr        = (dst == SEL_MX) ? m_x : m_y;
        data        = res;
        m_mem[addr] = res;
      end
    end else if (ins[11:8] == OPC_LDX) begin
      m_x = ins[7:0];
    end else if (ins[11:8] == OPC_LDY) begin
      m_y = ins[7:0];
    end else if (ins[11:4] == OPC_SETF) begin
      m_flags = m_flags | ins[3:0];
    end else if (ins[11:4] == OPC_RSTF) begin
      m_flags = m_flags & ~ins[3:0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    logic    exp_we;
    addr8_t  exp_addr;
    nibble_t exp_data;
    int      we_count;
    arst_n  = 1'b0;
    m_a     = '0;
    m_b     = '0;
    m_x     = '0;
    m_y     = '0;
    m_flags = '0;
    build_program();
    for (int a = 0; a < 256; a++) begin
      ram[a]   = a[7:4] ^ {a[2:0], a[3]};
      m_mem[a] = ram[a];
    end
    repeat (RST_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
    for (int k = 0; k < PROG_LEN; k++) begin
      execute_model(rom[k], exp_we, exp_addr, exp_data);
      we_count = 0;
      for (int j = 0; j < 7; j++) begin
        @(negedge clk);
        check_value("rom_addr", rom_addr, k);
        if (ram_we) begin
          we_count++;
          check_value("ram_we phase", j, 5);
          check_value("ram_addr", ram_addr, exp_addr);
          check_value("ram_wdata", ram_wdata, exp_data);
          ram[ram_addr] = ram_wdata;
        end
      end
      check_value("ram_we pulses", we_count, exp_we);
      check_value("flags", flags, m_flags); // settled in PH_NEXT.
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: vlog.f
design/cpu4_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/operand_stage.sv
design/alu_stage.sv
design/writeback_stage.sv
design/cpu4_core.sv
verif/cpu4_checker.sv
verif/cpu4_tb.sv

// File: Makefile
SIM  := obj_dir/Vcpu4_tb
SRCS := $(wildcard design/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module cpu4_tb \
		-Mdir obj_dir -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
